/* source/fp_fmt_pkg.sv */
// Floating-point format encoding, field widths and lane layout of the slice
package fp_fmt_pkg;

  // ----------------------------------------
  // Formats
  // ----------------------------------------
  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2  // e5m2
  } fp_fmt_e;

  localparam int unsigned NUM_FMTS = 3;

  // Indexed by the fp_fmt_e value
  localparam int unsigned FMT_WIDTH [NUM_FMTS] = '{32, 16, 8};
  localparam int unsigned EXP_WIDTH [NUM_FMTS] = '{8, 5, 5};
  localparam int unsigned MAN_WIDTH [NUM_FMTS] = '{23, 10, 2};

  // ----------------------------------------
  // Lane layout
  // ----------------------------------------
  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = SLICE_WIDTH / 8; // Narrowest format sets the count

  // Bit f of fmts set when the lane handles format f
  typedef struct packed {
    logic [NUM_FMTS-1:0] fmts;
    int unsigned         width;
  } lane_cfg_t;

  // Lane 0 takes every format, lane 1 the 16 and 8 bit ones, lanes 2 and 3 only FP8
  localparam lane_cfg_t LANE_FMTS [NUM_LANES] = '{
    '{fmts: 3'b111, width: 32},
    '{fmts: 3'b110, width: 16},
    '{fmts: 3'b100, width: 8},
    '{fmts: 3'b100, width: 8}
  };

endpackage

/* source/slice_pkg.sv */
// Operation codes, status flags, request/response/side-data structs and pipeline depth
package slice_pkg;

  // ----------------------------------------
  // Operations and flags
  // ----------------------------------------
  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2,
    SGNJN = 3'd3,
    SGNJX = 3'd4
  } op_e;

  typedef struct packed {
    logic nv; // Invalid operation
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  typedef logic [3:0]                       tag_t;
  typedef logic [fp_fmt_pkg::NUM_LANES-1:0] simd_mask_t;

  // ----------------------------------------
  // Handshake payloads
  // ----------------------------------------
  typedef struct packed {
    logic [fp_fmt_pkg::SLICE_WIDTH-1:0] operand_a;
    logic [fp_fmt_pkg::SLICE_WIDTH-1:0] operand_b;
    op_e                                op;
    fp_fmt_pkg::fp_fmt_e                fmt;
    logic                               vectorial;
    tag_t                               tag;
    simd_mask_t                         simd_mask;
  } slice_req_t;

  typedef struct packed {
    logic [fp_fmt_pkg::SLICE_WIDTH-1:0] result;
    status_t                            status;
    tag_t                               tag;
  } slice_rsp_t;

  // Travels with lane 0 so the output side knows how to pack
  typedef struct packed {
    fp_fmt_pkg::fp_fmt_e fmt;
    logic                vectorial;
    tag_t                tag;
  } side_data_t;

  localparam int unsigned NUM_PIPE_REGS = 2;

endpackage

/* source/lane_pipe.sv */
// Valid/ready register pipeline with flush, generic over the payload type
`timescale 1ns/100ps

module lane_pipe #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = slice_pkg::NUM_PIPE_REGS
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t data_o,
  output logic     busy_o
);

  // Index i holds what sits behind i register stages
  logic     stage_valid [Depth+1];
  logic     stage_ready [Depth+1];
  payload_t stage_data  [Depth+1];

  assign stage_valid[0] = in_valid_i;
  assign stage_data[0]  = data_i;

  for (genvar i = 0; i < Depth; i++) begin : gen_stage
    logic     valid_q;
    payload_t data_q;
    logic     load;

    // Advance when the next stage takes the item or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q;
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
      if (!arst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0; // Drop everything in flight
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
  end

  assign stage_ready[Depth] = out_ready_i; // Ready enters from the downstream side
  assign in_ready_o         = stage_ready[0];
  assign out_valid_o        = stage_valid[Depth];
  assign data_o             = stage_data[Depth];

  // Any register stage holding an item
  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= Depth; i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

endmodule

/* source/minmax_lane.sv */
// One SIMD lane: per-format classify, min/max and sign injection, then the lane pipeline
`timescale 1ns/100ps

module minmax_lane #(
  parameter int unsigned  LaneIdx    = 0,
  localparam int unsigned LANE_WIDTH = fp_fmt_pkg::LANE_FMTS[LaneIdx].width
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [LANE_WIDTH-1:0] operand_a_i,
  input  logic [LANE_WIDTH-1:0] operand_b_i,
  input  slice_pkg::op_e        op_i,
  input  fp_fmt_pkg::fp_fmt_e   fmt_i,
  input  logic                  mask_i,
  input  slice_pkg::side_data_t side_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [LANE_WIDTH-1:0] result_o,
  output slice_pkg::status_t    status_o,
  output logic                  mask_o,
  output slice_pkg::side_data_t side_o,
  output logic                  busy_o
);

  typedef struct packed {
    logic [LANE_WIDTH-1:0] result;
    slice_pkg::status_t    status;
    logic                  mask;
  } lane_res_t;

  typedef struct packed {
    lane_res_t             res;
    slice_pkg::side_data_t side;
  } lane_side_res_t;

  logic [fp_fmt_pkg::NUM_FMTS-1:0][LANE_WIDTH-1:0] fmt_result;
  logic [fp_fmt_pkg::NUM_FMTS-1:0]                 fmt_nv;
  logic                                            is_minmax;
  logic [LANE_WIDTH-1:0]                           op_result;
  logic                                            op_nv;
  slice_pkg::status_t                              status_d;
  lane_res_t                                       res_d, res_q;

  assign is_minmax = (op_i == slice_pkg::MIN) | (op_i == slice_pkg::MAX);

  // ----------------------------------------
  // Operation per supported format
  // ----------------------------------------
  for (genvar f = 0; f < int'(fp_fmt_pkg::NUM_FMTS); f++) begin : gen_fmt
    if (fp_fmt_pkg::LANE_FMTS[LaneIdx].fmts[f]) begin : gen_supported
      localparam int unsigned FW = fp_fmt_pkg::FMT_WIDTH[f];
      localparam int unsigned EW = fp_fmt_pkg::EXP_WIDTH[f];
      localparam int unsigned MW = fp_fmt_pkg::MAN_WIDTH[f];
      localparam logic [FW-1:0] QNAN = {1'b0, {EW{1'b1}}, 1'b1, {(MW-1){1'b0}}};

      logic [FW-1:0] a, b, res;
      logic          a_nan, b_nan, a_lt_b, sign;

      assign a     = operand_a_i[FW-1:0]; // Bits above belong to other lanes
      assign b     = operand_b_i[FW-1:0];
      assign a_nan = (&a[FW-2 -: EW]) & (|a[MW-1:0]);
      assign b_nan = (&b[FW-2 -: EW]) & (|b[MW-1:0]);

      // Quiet bit clear means signalling
      assign fmt_nv[f] = is_minmax & ((a_nan & ~a[MW-1]) | (b_nan & ~b[MW-1]));

      // Sign-magnitude order, so -0 sits below +0
      always_comb begin : order
        if (a[FW-1] != b[FW-1]) begin
          a_lt_b = a[FW-1];
        end else if (a[FW-1]) begin
          a_lt_b = a[FW-2:0] > b[FW-2:0];
        end else begin
          a_lt_b = a[FW-2:0] < b[FW-2:0];
        end
      end

      always_comb begin : compute
        case (op_i)
          slice_pkg::SGNJ:  sign = b[FW-1];
          slice_pkg::SGNJN: sign = ~b[FW-1];
          slice_pkg::SGNJX: sign = a[FW-1] ^ b[FW-1];
          default:          sign = a[FW-1];
        endcase
        if (!is_minmax) begin
          res = {sign, a[FW-2:0]};
        end else if (a_nan & b_nan) begin
          res = QNAN;
        end else if (a_nan) begin
          res = b; // Lone NaN yields the other operand
        end else if (b_nan) begin
          res = a;
        end else if (op_i == slice_pkg::MIN) begin
          res = a_lt_b ? a : b;
        end else begin
          res = a_lt_b ? b : a;
        end
      end

      // Ones above the format width
      assign fmt_result[f] = LANE_WIDTH'({{LANE_WIDTH{1'b1}}, res});
    end else begin : gen_unsupported
      assign fmt_result[f] = '1;
      assign fmt_nv[f]     = 1'b0;
    end
  end

  always_comb begin : fmt_select
    case (fmt_i)
      fp_fmt_pkg::FP32: {op_result, op_nv} = {fmt_result[fp_fmt_pkg::FP32],
                                              fmt_nv[fp_fmt_pkg::FP32]};
      fp_fmt_pkg::FP16: {op_result, op_nv} = {fmt_result[fp_fmt_pkg::FP16],
                                              fmt_nv[fp_fmt_pkg::FP16]};
      fp_fmt_pkg::FP8:  {op_result, op_nv} = {fmt_result[fp_fmt_pkg::FP8],
                                              fmt_nv[fp_fmt_pkg::FP8]};
      default:          {op_result, op_nv} = {{LANE_WIDTH{1'b1}}, 1'b0};
    endcase
  end

  assign status_d = '{nv: op_nv, default: 1'b0};
  assign res_d    = '{result: op_result, status: status_d, mask: mask_i};

  // ----------------------------------------
  // Lane pipeline with side data on lane 0
  // ----------------------------------------
  if (LaneIdx == 0) begin : gen_side_pipe
    lane_side_res_t pipe_in, pipe_out;

    assign pipe_in = '{res: res_d, side: side_i};

    lane_pipe #(
      .payload_t ( lane_side_res_t          ),
      .Depth     ( slice_pkg::NUM_PIPE_REGS )
    ) i_lane_pipe (
      .clk_i, .arst_n_i, .flush_i, .in_valid_i, .in_ready_o,
      .data_i  ( pipe_in  ),
      .out_valid_o, .out_ready_i,
      .data_o  ( pipe_out ),
      .busy_o
    );

    assign res_q  = pipe_out.res;
    assign side_o = pipe_out.side;
  end else begin : gen_plain_pipe
    lane_pipe #(
      .payload_t ( lane_res_t               ),
      .Depth     ( slice_pkg::NUM_PIPE_REGS )
    ) i_lane_pipe (
      .clk_i, .arst_n_i, .flush_i, .in_valid_i, .in_ready_o,
      .data_i  ( res_d ),
      .out_valid_o, .out_ready_i,
      .data_o  ( res_q ),
      .busy_o
    );

    assign side_o = '0; // Only lane 0 side data is read
  end

  assign result_o = res_q.result;
  assign status_o = res_q.status;
  assign mask_o   = res_q.mask;

endmodule

/* source/result_packer.sv */
// Per-format packing of lane results with NaN-boxing and masked status collapse
`timescale 1ns/100ps

module result_packer (
  input  logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::SLICE_WIDTH-1:0] lane_results_i,
  input  slice_pkg::status_t [fp_fmt_pkg::NUM_LANES-1:0]                lane_status_i,
  input  slice_pkg::simd_mask_t                                         lane_masks_i,
  input  logic [fp_fmt_pkg::NUM_LANES-1:0]                              lane_valid_i,
  input  slice_pkg::side_data_t                                         side_i,
  output slice_pkg::slice_rsp_t                                         rsp_o
);

  logic [fp_fmt_pkg::NUM_FMTS-1:0][fp_fmt_pkg::SLICE_WIDTH-1:0] fmt_word;
  logic [fp_fmt_pkg::SLICE_WIDTH-1:0]                           result;
  slice_pkg::status_t                                           status;

  // ----------------------------------------
  // One packed word per format
  // ----------------------------------------
  for (genvar f = 0; f < int'(fp_fmt_pkg::NUM_FMTS); f++) begin : gen_fmt
    localparam int unsigned FW = fp_fmt_pkg::FMT_WIDTH[f];

    for (genvar n = 0; n < int'(fp_fmt_pkg::NUM_LANES); n++) begin : gen_lane
      if (fp_fmt_pkg::LANE_FMTS[n].fmts[f]) begin : gen_used
        // Idle lane leaves its part NaN-boxed
        assign fmt_word[f][n*FW +: FW] = lane_valid_i[n] ? lane_results_i[n][FW-1:0]
                                                         : {FW{1'b1}};
      end else if ((n + 1) * FW <= fp_fmt_pkg::SLICE_WIDTH) begin : gen_box
        assign fmt_word[f][n*FW +: FW] = '1;
      end
    end
  end

  always_comb begin : fmt_select
    case (side_i.fmt)
      fp_fmt_pkg::FP32: result = fmt_word[fp_fmt_pkg::FP32];
      fp_fmt_pkg::FP16: result = fmt_word[fp_fmt_pkg::FP16];
      fp_fmt_pkg::FP8:  result = fmt_word[fp_fmt_pkg::FP8];
      default:          result = '1;
    endcase
  end

  // ----------------------------------------
  // Status under the SIMD mask
  // ----------------------------------------
  always_comb begin : status_collapse
    status = '0;
    for (int unsigned n = 0; n < fp_fmt_pkg::NUM_LANES; n++) begin
      if (lane_valid_i[n] && lane_masks_i[n]) begin
        status = status | lane_status_i[n];
      end
    end
  end

  assign rsp_o = '{result: result, status: status, tag: side_i.tag};

endmodule

/* source/minmax_slice.sv */
// Top of the SIMD min/max and sign-injection slice: operand slicing, lanes, handshakes, packing
`timescale 1ns/100ps

module minmax_slice (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  slice_pkg::slice_req_t req_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output slice_pkg::slice_rsp_t rsp_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  logic [fp_fmt_pkg::NUM_LANES-1:0]                              lane_in_ready;
  logic [fp_fmt_pkg::NUM_LANES-1:0]                              lane_out_valid;
  logic [fp_fmt_pkg::NUM_LANES-1:0]                              lane_busy;
  logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::SLICE_WIDTH-1:0] lane_result;
  slice_pkg::status_t [fp_fmt_pkg::NUM_LANES-1:0]                lane_status;
  slice_pkg::simd_mask_t                                         lane_masks;
  slice_pkg::side_data_t [fp_fmt_pkg::NUM_LANES-1:0]             lane_side;
  slice_pkg::side_data_t                                         side_d;
  slice_pkg::side_data_t                                         side_q;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  assign side_d     = '{fmt: req_i.fmt, vectorial: req_i.vectorial, tag: req_i.tag};
  assign in_ready_o = lane_in_ready[0]; // Lane 0 speaks for the slice
  assign side_q     = lane_side[0];

  for (genvar lane = 0; lane < int'(fp_fmt_pkg::NUM_LANES); lane++) begin : gen_lanes
    localparam int unsigned LANE_WIDTH = fp_fmt_pkg::LANE_FMTS[lane].width;

    logic                               in_valid, out_valid, out_ready, lane_used;
    logic [fp_fmt_pkg::SLICE_WIDTH-1:0] operand_a, operand_b;
    logic [LANE_WIDTH-1:0]              lane_out;

    // Upper lanes only take vectors, and only together with lane 0
    assign in_valid = in_valid_i & fp_fmt_pkg::LANE_FMTS[lane].fmts[req_i.fmt] &
                      ((lane == 0) | (req_i.vectorial & lane_in_ready[0]));

    // Lane slice sits at lane times the format width
    assign operand_a = req_i.operand_a >> (lane * fp_fmt_pkg::FMT_WIDTH[req_i.fmt]);
    assign operand_b = req_i.operand_b >> (lane * fp_fmt_pkg::FMT_WIDTH[req_i.fmt]);

    minmax_lane #(
      .LaneIdx ( lane )
    ) i_minmax_lane (
      .clk_i,
      .arst_n_i,
      .flush_i,
      .in_valid_i  ( in_valid                    ),
      .in_ready_o  ( lane_in_ready[lane]         ),
      .operand_a_i ( operand_a[LANE_WIDTH-1:0]   ),
      .operand_b_i ( operand_b[LANE_WIDTH-1:0]   ),
      .op_i        ( req_i.op                    ),
      .fmt_i       ( req_i.fmt                   ),
      .mask_i      ( req_i.simd_mask[lane]       ),
      .side_i      ( side_d                      ),
      .out_valid_o ( out_valid                   ),
      .out_ready_i ( out_ready                   ),
      .result_o    ( lane_out                    ),
      .status_o    ( lane_status[lane]           ),
      .mask_o      ( lane_masks[lane]            ),
      .side_o      ( lane_side[lane]             ),
      .busy_o      ( lane_busy[lane]             )
    );

    // Upper lanes hand over only while the head result is a vector in a format they hold
    assign lane_used            = (lane == 0) |
                                  (side_q.vectorial &
                                   fp_fmt_pkg::LANE_FMTS[lane].fmts[side_q.fmt]);
    assign out_ready            = out_ready_i & lane_used;
    assign lane_out_valid[lane] = out_valid & lane_used;
    assign lane_result[lane]    = fp_fmt_pkg::SLICE_WIDTH'({{fp_fmt_pkg::SLICE_WIDTH{1'b1}},
                                                            lane_out});
  end

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  result_packer i_result_packer (
    .lane_results_i ( lane_result    ),
    .lane_status_i  ( lane_status    ),
    .lane_masks_i   ( lane_masks     ),
    .lane_valid_i   ( lane_out_valid ),
    .side_i         ( side_q         ),
    .rsp_o
  );

  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

endmodule

/* test/tb_ref_model.svh */
// Reference model for one slice request and typed compare tasks for the response
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// One element of width 1+ew+mw; nv returns the invalid flag
function automatic logic [31:0] ref_elem(input logic [31:0] a, input logic [31:0] b,
                                         input slice_pkg::op_e op, input int ew, input int mw,
                                         output logic nv);
  int          fw;
  logic [31:0] mag_mask, exp_ones, qbit, man_mask;
  logic        sa, sb, na, nb, sgn;
  longint      ka, kb;
  fw       = 1 + ew + mw;
  mag_mask = (32'd1 << (fw - 1)) - 1;
  exp_ones = ((32'd1 << ew) - 1) << mw;
  qbit     = 32'd1 << (mw - 1);
  man_mask = (qbit << 1) - 1;
  sa       = a[fw-1];
  sb       = b[fw-1];
  na       = ((a & exp_ones) == exp_ones) && ((a & man_mask) != 0);
  nb       = ((b & exp_ones) == exp_ones) && ((b & man_mask) != 0);
  nv       = 1'b0;
  if (op == slice_pkg::SGNJ || op == slice_pkg::SGNJN || op == slice_pkg::SGNJX) begin
    sgn = (op == slice_pkg::SGNJ) ? sb : (op == slice_pkg::SGNJN) ? ~sb : (sa ^ sb);
    return (32'(sgn) << (fw - 1)) | (a & mag_mask);
  end
  nv = (na && (a & qbit) == 0) || (nb && (b & qbit) == 0); // Signalling NaN seen
  if (na && nb) return exp_ones | qbit;
  if (na) return b;
  if (nb) return a;
  // Signed key puts -0 just below +0
  ka = sa ? -longint'(a & mag_mask) - 1 : longint'(a & mag_mask);
  kb = sb ? -longint'(b & mag_mask) - 1 : longint'(b & mag_mask);
  if (op == slice_pkg::MIN) return (ka < kb) ? a : b;
  return (ka < kb) ? b : a;
endfunction

function automatic slice_pkg::slice_rsp_t ref_slice(input slice_pkg::slice_req_t r);
  int                    fw, ew, mw;
  logic [63:0]           fmask;
  logic [31:0]           ea, eb, er;
  logic                  nv;
  slice_pkg::slice_rsp_t rsp;
  fw         = fp_fmt_pkg::FMT_WIDTH[int'(r.fmt)];
  ew         = fp_fmt_pkg::EXP_WIDTH[int'(r.fmt)];
  mw         = fp_fmt_pkg::MAN_WIDTH[int'(r.fmt)];
  fmask      = (64'd1 << fw) - 1;
  rsp.result = '1; // Unused parts stay NaN-boxed
  rsp.status = '0;
  rsp.tag    = r.tag;
  for (int n = 0; n * fw < fp_fmt_pkg::SLICE_WIDTH; n++) begin
    if (n == 0 || r.vectorial) begin
      ea = 32'((64'(r.operand_a) >> (n * fw)) & fmask);
      eb = 32'((64'(r.operand_b) >> (n * fw)) & fmask);
      er = ref_elem(ea, eb, r.op, ew, mw, nv);
      rsp.result = 32'((64'(rsp.result) & ~(fmask << (n * fw))) | (64'(er) << (n * fw)));
      if (r.simd_mask[n]) rsp.status.nv = rsp.status.nv | nv;
    end
  end
  return rsp;
endfunction

// ----------------------------------------
// Compare tasks
// ----------------------------------------
task automatic check_result(input logic [fp_fmt_pkg::SLICE_WIDTH-1:0] exp_v,
                            input logic [fp_fmt_pkg::SLICE_WIDTH-1:0] act_v);
  if (act_v !== exp_v) begin
    $display("Error at %0t: rsp_o.result expected %h, actual %h", $time, exp_v, act_v);
    fail_run();
  end
endtask

task automatic check_status(input slice_pkg::status_t exp_v, input slice_pkg::status_t act_v,
                            input slice_pkg::tag_t tag);
  if (act_v !== exp_v) begin
    $display("Error at %0t: rsp_o.status expected %b, actual %b (tag %0d)",
             $time, exp_v, act_v, tag);
    fail_run();
  end
endtask

task automatic check_tag(input slice_pkg::tag_t exp_v, input slice_pkg::tag_t act_v);
  if (act_v !== exp_v) begin
    $display("Error at %0t: rsp_o.tag expected %0d, actual %0d", $time, exp_v, act_v);
    fail_run();
  end
endtask

task automatic check_bit(input string name, input logic exp_v, input logic act_v);
  if (act_v !== exp_v) begin
    $display("Error at %0t: %s expected %b, actual %b", $time, name, exp_v, act_v);
    fail_run();
  end
endtask

`endif

/* test/tb_minmax_slice.sv */
// Testbench for the min/max slice: clock, reset, stimulus, scoreboard, checks and timeout
`timescale 1ns/100ps

module tb_minmax_slice;

  localparam int unsigned TOTAL_REQS     = 11 + 12 + 60 + 40 + 60 + 2;
  localparam int unsigned TIMEOUT_CYCLES = 2 * TOTAL_REQS + 200;

  localparam logic [31:0] ONE   = 32'h3f80_0000;
  localparam logic [31:0] M_TWO = 32'hc000_0000;
  localparam logic [31:0] P_Z   = 32'h0000_0000;
  localparam logic [31:0] N_Z   = 32'h8000_0000;
  localparam logic [31:0] Q_NAN = 32'h7fc0_0000;
  localparam logic [31:0] S_NAN = 32'h7f80_0001;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic                  flush;
  slice_pkg::slice_req_t req;
  logic                  in_valid, in_ready;
  slice_pkg::slice_rsp_t rsp;
  logic                  out_valid, out_ready, busy;

  slice_pkg::slice_rsp_t exp_q [$]; // Expected responses in request order
  slice_pkg::slice_rsp_t exp_rsp;
  slice_pkg::tag_t       next_tag;
  int unsigned           cycles;
  int                    ready_mode; // 0 always ready, 1 random, 2 stalled

  minmax_slice minmax_slice_i (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .flush_i     ( flush     ),
    .req_i       ( req       ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .rsp_o       ( rsp       ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  always #20 clk = ~clk;

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1, "Run stopped at first failure");
  endtask

  `include "tb_ref_model.svh"

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic slice_pkg::slice_req_t build_req(
      input logic [31:0] a, input logic [31:0] b, input slice_pkg::op_e op,
      input fp_fmt_pkg::fp_fmt_e fmt, input logic vec, input slice_pkg::simd_mask_t mask);
    slice_pkg::slice_req_t r;
    r = '{operand_a: a, operand_b: b, op: op, fmt: fmt, vectorial: vec, tag: '0,
          simd_mask: mask};
    return r;
  endfunction

  // Random element with zeros, NaNs and infinities mixed in
  function automatic logic [31:0] rand_elem(input fp_fmt_pkg::fp_fmt_e fmt);
    int          fw, ew, mw;
    logic [31:0] exp_ones, sgn, fmask;
    fw       = fp_fmt_pkg::FMT_WIDTH[int'(fmt)];
    ew       = fp_fmt_pkg::EXP_WIDTH[int'(fmt)];
    mw       = fp_fmt_pkg::MAN_WIDTH[int'(fmt)];
    fmask    = 32'((64'd1 << fw) - 1);
    exp_ones = ((32'd1 << ew) - 1) << mw;
    sgn      = ($urandom % 2) ? (32'd1 << (fw - 1)) : 32'd0;
    case ($urandom % 8)
      0:       return sgn;
      1:       return exp_ones | (32'd1 << (mw - 1));
      2:       return sgn | exp_ones | 32'd1;
      3:       return sgn | exp_ones;
      default: return $urandom & fmask;
    endcase
  endfunction

  function automatic logic [31:0] rand_word(input fp_fmt_pkg::fp_fmt_e fmt);
    int          fw;
    logic [31:0] w;
    fw = fp_fmt_pkg::FMT_WIDTH[int'(fmt)];
    w  = '0;
    for (int n = 0; n * fw < 32; n++) w = w | (rand_elem(fmt) << (n * fw));
    return w;
  endfunction

  task automatic send_req(input slice_pkg::slice_req_t r);
    req      = r;
    req.tag  = next_tag;
    next_tag = next_tag + 1;
    in_valid = 1'b1;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
    #2;
  endtask

  // ----------------------------------------
  // Scoreboard and timeout
  // ----------------------------------------
  always @(posedge clk) begin
    if (arst_n && flush) begin
      exp_q.delete(); // In-flight items are dropped
    end else if (arst_n) begin
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("A response left the DUT with no request outstanding");
          fail_run();
        end else begin
          exp_rsp = exp_q.pop_front();
          check_tag(exp_rsp.tag, rsp.tag);
          check_result(exp_rsp.result, rsp.result);
          check_status(exp_rsp.status, rsp.status, rsp.tag);
        end
      end
      if (in_valid && in_ready) exp_q.push_back(ref_slice(req));
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with responses still missing", cycles);
      fail_run();
    end
  end

  always @(posedge clk) begin
    #2;
    case (ready_mode)
      0:       out_ready = 1'b1;
      1:       out_ready = ($urandom % 4) != 0;
      default: out_ready = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main
    slice_pkg::slice_req_t r;
    fp_fmt_pkg::fp_fmt_e   fmt;
    logic [31:0]           a, b, fm;
    int                    fw;
    void'($urandom(32'hb94f917c));
    cycles     = 0;
    next_tag   = '0;
    ready_mode = 0;
    arst_n     = 1'b0;
    flush      = 1'b0;
    req        = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check_bit("out_valid_o", 1'b0, out_valid);
    check_bit("busy_o", 1'b0, busy);
    check_bit("in_ready_o", 1'b1, in_ready);

    // Scalar FP32 corner cases
    send_req(build_req(ONE, M_TWO, slice_pkg::MIN, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(ONE, M_TWO, slice_pkg::MAX, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(P_Z, N_Z, slice_pkg::MIN, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(N_Z, P_Z, slice_pkg::MAX, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(Q_NAN, ONE, slice_pkg::MIN, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(ONE, Q_NAN, slice_pkg::MAX, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(Q_NAN, Q_NAN, slice_pkg::MIN, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(S_NAN, ONE, slice_pkg::MAX, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(ONE, M_TWO, slice_pkg::SGNJ, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(ONE, M_TWO, slice_pkg::SGNJN, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(M_TWO, M_TWO, slice_pkg::SGNJX, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    wait_drain();

    // Garbage above a scalar narrow element must not leak
    for (int i = 0; i < 12; i++) begin
      fmt = (i % 2) ? fp_fmt_pkg::FP16 : fp_fmt_pkg::FP8;
      fm  = 32'((64'd1 << fp_fmt_pkg::FMT_WIDTH[int'(fmt)]) - 1);
      a   = ($urandom & ~fm) | rand_elem(fmt);
      b   = ($urandom & ~fm) | rand_elem(fmt);
      send_req(build_req(a, b, slice_pkg::op_e'($urandom % 5), fmt, 1'b0, 4'b1111));
    end
    wait_drain();

    // Random vectors
    for (int i = 0; i < 60; i++) begin
      fmt = ($urandom % 2) ? fp_fmt_pkg::FP16 : fp_fmt_pkg::FP8;
      r   = build_req(rand_word(fmt), rand_word(fmt), slice_pkg::op_e'($urandom % 5), fmt,
                      1'b1, slice_pkg::simd_mask_t'($urandom));
      send_req(r);
    end
    wait_drain();

    // Signalling NaNs in chosen lanes under random masks
    for (int i = 0; i < 40; i++) begin
      fmt = ($urandom % 2) ? fp_fmt_pkg::FP16 : fp_fmt_pkg::FP8;
      fw  = fp_fmt_pkg::FMT_WIDTH[int'(fmt)];
      fm  = 32'((64'd1 << fw) - 1);
      a   = '0;
      b   = '0;
      for (int n = 0; n * fw < 32; n++) begin
        a = a | ((($urandom & fm) & ~(32'd1 << (fw - 2))) << (n * fw)); // Top exponent bit clear
        b = b | ((($urandom & fm) & ~(32'd1 << (fw - 2))) << (n * fw));
        if ($urandom % 3 == 0) begin
          if ($urandom % 2) a = (a & ~(fm << (n * fw))) | (rand_elem_snan(fmt) << (n * fw));
          else b = (b & ~(fm << (n * fw))) | (rand_elem_snan(fmt) << (n * fw));
        end
      end
      send_req(build_req(a, b, ($urandom % 2) ? slice_pkg::MAX : slice_pkg::MIN, fmt, 1'b1,
                         slice_pkg::simd_mask_t'($urandom)));
    end
    wait_drain();

    // Back-to-back requests against random back-pressure
    ready_mode = 1;
    for (int i = 0; i < 60; i++) begin
      fmt = fp_fmt_pkg::fp_fmt_e'($urandom % 3);
      send_req(build_req(rand_word(fmt), rand_word(fmt), slice_pkg::op_e'($urandom % 5), fmt,
                         1'(($urandom % 2)), slice_pkg::simd_mask_t'($urandom)));
    end
    wait_drain();

    // Flush with the pipe stalled
    ready_mode = 2;
    @(posedge clk);
    #2;
    send_req(build_req(ONE, M_TWO, slice_pkg::MIN, fp_fmt_pkg::FP32, 1'b0, 4'b0001));
    send_req(build_req(rand_word(fp_fmt_pkg::FP8), rand_word(fp_fmt_pkg::FP8),
                       slice_pkg::MAX, fp_fmt_pkg::FP8, 1'b1, 4'b1111));
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
    check_bit("busy_o", 1'b0, busy);
    check_bit("out_valid_o", 1'b0, out_valid);
    ready_mode = 0;

    repeat (4) @(posedge clk);
    #2;
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      fail_run();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  function automatic logic [31:0] rand_elem_snan(input fp_fmt_pkg::fp_fmt_e fmt);
    int ew, mw, fw;
    ew = fp_fmt_pkg::EXP_WIDTH[int'(fmt)];
    mw = fp_fmt_pkg::MAN_WIDTH[int'(fmt)];
    fw = fp_fmt_pkg::FMT_WIDTH[int'(fmt)];
    return (32'($urandom % 2) << (fw - 1)) | (((32'd1 << ew) - 1) << mw) | 32'd1;
  endfunction

endmodule

/* compile.f */
+incdir+test
source/fp_fmt_pkg.sv
source/slice_pkg.sv
source/lane_pipe.sv
source/minmax_lane.sv
source/result_packer.sv
source/minmax_slice.sv
test/tb_minmax_slice.sv

/* Makefile */
# Verilator build and run of the min/max slice testbench

TOP = tb_minmax_slice

all: run

build:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Testbench failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Testbench passed" sim.log || (echo "Simulation did not finish"; exit 1)

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
